/* Bender.yml */
package:
  name: agc_adcp

sources:
  - include_dirs:
      - .
    files:
      - dsa_pkg.sv
      - alarm_pkg.sv
      - alarm_sync.sv
      - ps_dsa_request.sv
      - dsa_arbiter.sv
      - agc_adcp_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - agc_adcp_sva.sv
      - agc_adcp_checker.sv
      - agc_adcp_tb.sv

/* agc_adcp_checker.sv */
`include "agc_config.svh"

module agc_adcp_checker
    import dsa_pkg::*;
(
    input logic       axi_clk,
    input logic       reset,
    input logic       clk_en,
    input logic       adc_over_voltage,
    input logic       adcp_disable,
    input dsa_code_t  ps_rxdsa,
    input logic       ps_bypass_lna,
    input logic       service_done,
    input dsa_drive_t dsa_drive,
    input dsa_code_t  pl_rxdsa,
    input logic       service
);

    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;
    int test_count  = 0;
    int test_failed = 0;
    int test_err_start = 0;
    int rises = 0;
    int ov_cnt = 0;
    int le_count = 0;

    // Enabled edges that have seen the current processor code
    int        ps_age = 0;
    dsa_code_t ps_last;

    // Inputs as seen by the next rising edge
    logic en_prev, ov_prev, dis_prev, done_prev, service_prev, le_prev;

    task automatic check_fail(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic note_failure(input string msg);
        $display("ERROR: %s", msg);
        error_count++;
    endtask

    // Closes one test line
    task automatic finish_test(input string name, input string detail);
        test_count++;
        if (error_count != test_err_start) begin
            test_failed++;
        end
        $display("test %-15s %s %s", name,
                 (error_count == test_err_start) ? "ok    " : "failed", detail);
        test_err_start = error_count;
        rises = 0;
        le_count = 0;
    endtask

    task automatic check_reset();
        if (pl_rxdsa !== dsa_code_t'(`DSA_ATTN_MAX)) begin
            check_fail($sformatf("code after reset is %0d", pl_rxdsa));
        end
        if (dsa_drive.le !== 1'b0 || service !== 1'b0) begin
            check_fail("le or service high after reset");
        end
        finish_test("reset_values", "");
    endtask

    task automatic end_test(input string name, input int exp_code, input int min_rises,
                            input int exp_le);
        if (pl_rxdsa !== dsa_code_t'(exp_code)) begin
            check_fail($sformatf("%s code %0d, expected %0d", name, pl_rxdsa, exp_code));
        end
        if (rises < min_rises) begin
            check_fail($sformatf("%s saw %0d service requests, expected at least %0d",
                                 name, rises, min_rises));
        end
        if (le_count != exp_le) begin
            check_fail($sformatf("%s saw %0d le pulses, expected %0d",
                                 name, le_count, exp_le));
        end
        finish_test(name, $sformatf("code %0d service rises %0d le %0d",
                                    pl_rxdsa, rises, le_count));
    endtask

    task automatic report();
        $display("tests %0d, failed %0d, check errors %0d",
                 test_count, test_failed, error_count);
    endtask

    // Outputs are settled at the falling edge
    always @(negedge axi_clk) begin
        if (reset) begin
            en_prev = 1'b0;
            ov_prev = 1'b0;
            dis_prev = 1'b0;
            done_prev = 1'b0;
            service_prev = 1'b0;
            le_prev = 1'b0;
            ov_cnt = 0;
            ps_last = ps_rxdsa;
            ps_age = 0;
        end else begin
            if (dsa_drive.code !== pl_rxdsa) begin
                check_fail("drive code differs from read-back code");
            end
            if (dsa_drive.lna_bypass !== ps_bypass_lna) begin
                check_fail("lna_bypass does not follow the request");
            end
            // State moves only on enabled edges
            if (en_prev) begin
                if (dsa_drive.le && le_prev) begin
                    check_fail("le high for two enabled cycles");
                end
                le_prev = dsa_drive.le;
                ps_age++;
                if (dsa_drive.le) begin
                    le_count++;
                    // Two retiming stages and the update take 3 enabled edges
                    if (ps_age != 3) begin
                        check_fail($sformatf("le %0d enabled cycles after the write, expected 3",
                                             ps_age));
                    end
                end
                if (ov_prev && !dis_prev) begin
                    ov_cnt++;
                end else begin
                    ov_cnt = 0;
                end
            end
            if (dsa_drive.le && pl_rxdsa !== ps_rxdsa) begin
                check_fail($sformatf("le with code %0d, processor asked %0d",
                                     pl_rxdsa, ps_rxdsa));
            end
            // Sync, retime and update take 4 enabled edges
            if (ov_cnt >= 4 && pl_rxdsa !== dsa_code_t'(`DSA_ATTN_MAX)) begin
                check_fail($sformatf("code %0d during over-voltage", pl_rxdsa));
            end
            if (service && !service_prev) begin
                rises++;
            end
            if (!service && service_prev && !(en_prev && done_prev)) begin
                check_fail("service dropped without an acknowledge");
            end
            // A new processor code is first seen by the next rising edge
            if (ps_rxdsa !== ps_last) begin
                ps_last = ps_rxdsa;
                ps_age = 0;
            end
            en_prev = clk_en;
            ov_prev = adc_over_voltage;
            dis_prev = adcp_disable;
            done_prev = service_done;
            service_prev = service;
        end
    end

endmodule

/* agc_adcp_sva.sv */
`include "agc_config.svh"

module agc_adcp_sva
    import dsa_pkg::*;
    import alarm_pkg::*;
(
    input logic          axi_clk,
    input logic          reset,
    input logic          clk_en,
    input alarm_status_t alarms,
    input logic          adcp_disable,
    input logic          service_done,
    input dsa_drive_t    dsa_drive,
    input service_t      service
);

    timeunit 1ns;
    timeprecision 1ps;

    // le value after the last enabled edge
    logic le_last;

    // Assertion failures so far
    int fail_count = 0;

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            le_last <= 1'b0;
        end else if (clk_en) begin
            le_last <= dsa_drive.le;
        end
    end

    // Latch enable never spans two enabled cycles
    le_single: assert property (@(posedge axi_clk) disable iff (reset)
        (clk_en && dsa_drive.le) |-> !le_last)
        else begin
            fail_count++;
            $error("le held for more than one enabled cycle");
        end

    // Synchronized over-voltage forces full attenuation on the next update
    ov_forces_max: assert property (@(posedge axi_clk) disable iff (reset)
        (clk_en && !adcp_disable && alarms.over_voltage_level)
        |=> (dsa_drive.code == dsa_code_t'(`DSA_ATTN_MAX)))
        else begin
            fail_count++;
            $error("over-voltage did not force full attenuation");
        end

    // Request drops only on an acknowledged enabled cycle
    service_fall: assert property (@(posedge axi_clk) disable iff (reset)
        $fell(service.request) |-> $past(clk_en && service_done))
        else begin
            fail_count++;
            $error("service fell without service_done");
        end

endmodule

bind dsa_arbiter agc_adcp_sva sva_i (.*);

/* agc_adcp_tb.sv */
module agc_adcp_tb
    import dsa_pkg::*;
    import alarm_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic       axi_clk, reset, clk_en;
    logic       adc_over_range, adc_over_voltage, adcp_disable;
    logic       ps_bypass_lna, service_done, service;
    dsa_code_t  ps_rxdsa, pl_rxdsa;
    dsa_drive_t dsa_drive;

    // Vector table
    string row_name [0:31];
    int    row_val  [0:31][0:8];
    int    row_count = 0;
    int    limit_cycles = 0;
    bit    loaded = 0;

    logic        gap_mode = 1'b0;
    logic [31:0] lcg_state = 32'hf448_1603;
    int          done_delay = 2;
    int          ack_cnt;

    agc_adcp_top dut_i (.*);

    agc_adcp_checker checker_i (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always #20 axi_clk = ~axi_clk;

    // Random clk_en gaps with roughly one cycle in four idle
    always @(posedge axi_clk) begin
        if (gap_mode) begin
            lcg_state = lcg_next(lcg_state);
            clk_en <= (lcg_state[31:30] != 2'b00);
        end else begin
            clk_en <= 1'b1;
        end
    end

    // Software model acknowledging after done_delay enabled cycles
    always @(posedge axi_clk) begin
        if (reset) begin
            ack_cnt <= 0;
            service_done <= 1'b0;
        end else if (clk_en) begin
            if (service_done) begin
                service_done <= 1'b0;
            end else if (service && ack_cnt >= done_delay) begin
                service_done <= 1'b1;
                ack_cnt <= 0;
            end else if (service) begin
                ack_cnt <= ack_cnt + 1;
            end
        end
    end

    task automatic wait_en(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge axi_clk);
            if (clk_en) begin
                seen++;
            end
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        string name;
        int    v [0:8];
        fd = $fopen("agc_adcp_vectors.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open agc_adcp_vectors.txt");
            return;
        end
        while ($fgets(line, fd)) begin
            if (line.len() < 4 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d", name,
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
            if (n == 10) begin
                row_name[row_count] = name;
                for (int k = 0; k < 9; k++) begin
                    row_val[row_count][k] = v[k];
                end
                // Rough length in enabled cycles
                limit_cycles += 2 * v[3] * v[4] + v[5] + 3 * v[6] + 60;
                row_count++;
            end
        end
        $fclose(fd);
        limit_cycles = limit_cycles * 2 + 100;
    endtask

    // Alarms start together and the processor write lands inside them
    task automatic run_row(input int i);
        int cnt;
        int exp_le;
        @(posedge axi_clk);
        // One latch pulse when the code changes and no active alarm blocks it
        exp_le = (dsa_code_t'(row_val[i][2]) != ps_rxdsa) &&
                 (row_val[i][1] != 0 || (row_val[i][3] == 0 && row_val[i][5] == 0));
        gap_mode <= (row_val[i][0] != 0);
        adcp_disable <= (row_val[i][1] != 0);
        ps_bypass_lna <= ~ps_bypass_lna;
        done_delay = row_val[i][6];
        fork
            begin
                for (int k = 0; k < row_val[i][3]; k++) begin
                    adc_over_range <= 1'b1;
                    wait_en(row_val[i][4]);
                    adc_over_range <= 1'b0;
                    wait_en(row_val[i][4]);
                end
            end
            begin
                if (row_val[i][5] > 0) begin
                    adc_over_voltage <= 1'b1;
                    wait_en(row_val[i][5]);
                    adc_over_voltage <= 1'b0;
                end
            end
            begin
                wait_en(4);
                ps_rxdsa <= dsa_code_t'(row_val[i][2]);
            end
        join
        wait_en(12);
        cnt = 0;
        while (service && cnt < 400) begin
            wait_en(1);
            cnt++;
        end
        if (service) begin
            checker_i.note_failure({row_name[i], ": service request never cleared"});
        end
        wait_en(8);
        checker_i.end_test(row_name[i], row_val[i][7], row_val[i][8], exp_le);
    endtask

    initial begin
        axi_clk = 1'b0;
        reset = 1'b1;
        clk_en = 1'b0;
        adc_over_range = 1'b0;
        adc_over_voltage = 1'b0;
        adcp_disable = 1'b0;
        ps_bypass_lna = 1'b0;
        service_done = 1'b0;
        ps_rxdsa = '1;
        load_vectors();
        loaded = 1;
        repeat (2) @(posedge axi_clk);
        reset <= 1'b0;
        @(negedge axi_clk);
        checker_i.check_reset();
        for (int i = 0; i < row_count; i++) begin
            run_row(i);
        end
        checker_i.report();
        if (checker_i.error_count == 0 && row_count > 0 &&
            dut_i.dsa_arbiter_i.sva_i.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog sized from the vector table
    initial begin
        wait (loaded);
        repeat (limit_cycles) @(posedge axi_clk);
        $display("ERROR: simulation did not finish in %0d cycles", limit_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* agc_adcp_top.sv */
module agc_adcp_top
    import dsa_pkg::*;
    import alarm_pkg::*;
(
    input  logic       axi_clk,
    input  logic       reset,
    input  logic       clk_en,
    input  logic       adc_over_range,
    input  logic       adc_over_voltage,
    input  logic       adcp_disable,
    input  dsa_code_t  ps_rxdsa,
    input  logic       ps_bypass_lna,
    input  logic       service_done,
    output dsa_drive_t dsa_drive,
    output dsa_code_t  pl_rxdsa,
    output logic       service
);

    // Synchronized alarm state
    alarm_status_t alarms;

    // Processor request after retiming
    dsa_code_t ps_code;
    logic      ps_change;

    // Full service pair from the arbiter
    service_t  service_state;

    // ADC alarm synchronizers and over-range pulse
    alarm_sync alarm_sync_i (
        .axi_clk          (axi_clk),
        .reset            (reset),
        .clk_en           (clk_en),
        .adc_over_range   (adc_over_range),
        .adc_over_voltage (adc_over_voltage),
        .alarms           (alarms)
    );

    // Processor code retiming and change detect
    ps_dsa_request ps_dsa_request_i (
        .axi_clk   (axi_clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .ps_rxdsa  (ps_rxdsa),
        .ps_code   (ps_code),
        .ps_change (ps_change)
    );

    // Code selection and service tracking
    dsa_arbiter dsa_arbiter_i (
        .axi_clk       (axi_clk),
        .reset         (reset),
        .clk_en        (clk_en),
        .alarms        (alarms),
        .adcp_disable  (adcp_disable),
        .ps_code       (ps_code),
        .ps_change     (ps_change),
        .ps_bypass_lna (ps_bypass_lna),
        .service_done  (service_done),
        .dsa_drive     (dsa_drive),
        .pl_rxdsa      (pl_rxdsa),
        .service       (service_state)
    );

    // Only the request leaves the block
    assign service = service_state.request;

endmodule

/* agc_adcp_vectors.txt */
# name mode(0 steady, 1 gaps) disable ps_code ovr_count ovr_len ov_len done_delay
# expected_code min_service_rises
ps_code_40     0 0  40 0 0  0  2  40 1
ps_same_40     1 0  40 0 0  0  2  40 0
ps_gap_5       1 0   5 0 0  0  2   5 1
ovr_two_edges  0 0 100 2 8  0  2  53 2
ovr_clip       1 0 100 4 8  0  2 127 2
ps_after_clip  0 0  20 0 0  0  2  20 1
ov_wins        0 0  90 1 8 24  2 127 1
ps_code_33     1 0  33 0 0  0  2  33 1
disable_alarms 0 1  50 2 8 24  2  50 1
pending_ack    0 0  50 2 8  0 30  98 2
ov_hold_gaps   1 0   8 0 0 30  3 127 1

/* agc_config.svh */
`ifndef AGC_CONFIG_SVH
`define AGC_CONFIG_SVH

// Step attenuator code width
// Each LSB is 0.25 dB of attenuation
`define DSA_WIDTH 7

// Full attenuation of 31.75 dB
// Also the power-up default of the attenuator
`define DSA_ATTN_MAX 127

// Over-range step of 6 dB
`define DSA_ATTN_INC 24

// Depth of the ADC alarm synchronizers
`define ALARM_SYNC_STAGES 2

// Length of the stretched over-range pulse
// Counted in enabled cycles
`define OVR_PULSE_WIDTH 4

`endif

/* alarm_pkg.sv */
package alarm_pkg;

    // ADC alarm state after synchronization
    typedef struct packed {
        // Over-voltage level, synchronized and retimed
        logic over_voltage_level;
        // Over-range level, synchronized and retimed
        logic over_range_level;
        // Stretched pulse on an over-range rising edge
        logic over_range_pulse;
    } alarm_status_t;

    // Service request pair toward software
    typedef struct packed {
        // Held high until software acknowledges
        logic request;
        // Another event arrived before the acknowledge
        logic pending;
    } service_t;

endpackage

/* alarm_sync.sv */
`include "agc_config.svh"

module alarm_sync
    import alarm_pkg::*;
(
    input  logic          axi_clk,
    input  logic          reset,
    input  logic          clk_en,
    input  logic          adc_over_range,
    input  logic          adc_over_voltage,
    output alarm_status_t alarms
);

    // Pulse counter wide enough for the full stretch length
    localparam int cnt_w = $clog2(`OVR_PULSE_WIDTH + 1);

    // Both alarms share one shift register
    // Bit 1 is over-voltage, bit 0 is over-range
    logic [`ALARM_SYNC_STAGES-1:0][1:0] sync_q;
    logic [1:0]                         sync_out;

    // Previous synchronized over-range for edge detection
    logic             over_range_prev_q;
    logic             over_range_edge;
    logic [cnt_w-1:0] pulse_cnt_q;

    // Last synchronizer stage
    assign sync_out = sync_q[`ALARM_SYNC_STAGES-1];

    // Rising edge of the synchronized over-range level
    assign over_range_edge = sync_out[0] & ~over_range_prev_q;

    // Synchronizer chain
    // Glitches shorter than a clock period can be missed
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            sync_q <= '0;
        end else if (clk_en) begin
            sync_q[0] <= {adc_over_voltage, adc_over_range};
            for (int i = 1; i < `ALARM_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Edge history and pulse stretch counter
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            over_range_prev_q <= 1'b0;
            pulse_cnt_q       <= '0;
        end else if (clk_en) begin
            over_range_prev_q <= sync_out[0];
            // A new edge restarts the stretch
            if (over_range_edge) begin
                pulse_cnt_q <= cnt_w'(`OVR_PULSE_WIDTH - 1);
            end else if (pulse_cnt_q != '0) begin
                pulse_cnt_q <= pulse_cnt_q - 1'b1;
            end
        end
    end

    // Registered alarm outputs
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            alarms <= '0;
        end else if (clk_en) begin
            alarms.over_voltage_level <= sync_out[1];
            alarms.over_range_level   <= sync_out[0];
            // High on the edge cycle plus the remaining count
            alarms.over_range_pulse   <= over_range_edge | (pulse_cnt_q != '0);
        end
    end

endmodule

/* dsa_arbiter.sv */
`include "agc_config.svh"

module dsa_arbiter
    import dsa_pkg::*;
    import alarm_pkg::*;
(
    input  logic          axi_clk,
    input  logic          reset,
    input  logic          clk_en,
    input  alarm_status_t alarms,
    input  logic          adcp_disable,
    input  dsa_code_t     ps_code,
    input  logic          ps_change,
    input  logic          ps_bypass_lna,
    input  logic          service_done,
    output dsa_drive_t    dsa_drive,
    output dsa_code_t     pl_rxdsa,
    output service_t      service
);

    localparam dsa_code_t attn_max = dsa_code_t'(`DSA_ATTN_MAX);
    localparam dsa_code_t attn_inc = dsa_code_t'(`DSA_ATTN_INC);
    // Highest code that still takes a full step
    localparam dsa_code_t attn_inc_limit = dsa_code_t'(`DSA_ATTN_MAX - `DSA_ATTN_INC);

    // Duplicated code registers, one per destination
    dsa_code_t code_q;
    dsa_code_t code_copy_q;
    dsa_code_t code_next;
    dsa_code_t code_inc;
    logic      le_q;

    logic      over_range_pulse_d_q;
    logic      alarm_present;
    logic      over_voltage_valid;
    logic      over_range_valid;
    logic      ps_valid;
    logic      ps_selected;

    logic      event_valid;
    logic      event_valid_d_q;
    logic      new_event;

    // Real-time alarm levels block processor requests
    // unless adaptive protection is disabled
    assign alarm_present = ~adcp_disable &
                           (alarms.over_voltage_level | alarms.over_range_level);

    // Over-voltage acts on the level, so the code is held while it lasts
    assign over_voltage_valid = ~adcp_disable & alarms.over_voltage_level;

    // One increment per over-range edge, taken on the stretched pulse start
    assign over_range_valid = ~adcp_disable &
                              alarms.over_range_pulse & ~over_range_pulse_d_q;

    assign ps_valid = ps_change & ~alarm_present;

    // Processor code only lands when no alarm wins the same cycle
    assign ps_selected = ps_valid & ~over_voltage_valid & ~over_range_valid;

    // 6 dB step clipped at full attenuation
    always_comb begin
        if (code_q > attn_inc_limit) begin
            code_inc = attn_max;
        end else begin
            code_inc = code_q + attn_inc;
        end
    end

    // Priority is over-voltage, then over-range, then processor
    always_comb begin
        if (over_voltage_valid) begin
            code_next = attn_max;
        end else if (over_range_valid) begin
            code_next = code_inc;
        end else if (ps_selected) begin
            code_next = ps_code;
        end else begin
            code_next = code_q;
        end
    end

    // Code registers and latch enable
    // le comes out in the same cycle as the new code
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            code_q               <= attn_max;
            code_copy_q          <= attn_max;
            le_q                 <= 1'b0;
            over_range_pulse_d_q <= 1'b0;
        end else if (clk_en) begin
            code_q               <= code_next;
            code_copy_q          <= code_next;
            le_q                 <= ps_selected;
            over_range_pulse_d_q <= alarms.over_range_pulse;
        end
    end

    // Front-end outputs
    assign dsa_drive.code       = code_q;
    assign dsa_drive.le         = le_q;
    // Bypass goes straight through from software
    assign dsa_drive.lna_bypass = ps_bypass_lna;

    // Read-back copy of the applied code
    assign pl_rxdsa = code_copy_q;

    // Any accepted event, edge detected for the service request
    assign event_valid = ps_valid | over_voltage_valid | over_range_valid;
    assign new_event   = event_valid & ~event_valid_d_q;

    // Service request and pending flag
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            event_valid_d_q <= 1'b0;
            service         <= '0;
        end else if (clk_en) begin
            event_valid_d_q <= event_valid;

            // Request rises on a new event or on a waiting one
            if (new_event) begin
                service.request <= 1'b1;
            end else if (service.pending && !service.request) begin
                service.request <= 1'b1;
            end else if (service_done) begin
                service.request <= 1'b0;
            end

            // Event during an open request is held as pending
            if (new_event && service.request) begin
                service.pending <= 1'b1;
            end else if (service.pending && service.request && service_done) begin
                // Kept so the request comes back next cycle
                service.pending <= 1'b1;
            end else if (service.pending && !service.request) begin
                service.pending <= 1'b0;
            end else if (service_done) begin
                service.pending <= 1'b0;
            end
        end
    end

endmodule

/* dsa_pkg.sv */
`include "agc_config.svh"

package dsa_pkg;

    // Attenuation code toward the step attenuator
    // Bit 6 is 16 dB, bit 5 is 8 dB, bit 4 is 4 dB, bit 3 is 2 dB
    // Bit 2 is 1 dB, bit 1 is 0.5 dB, bit 0 is 0.25 dB
    // All ones is the maximum of 31.75 dB
    typedef logic [`DSA_WIDTH-1:0] dsa_code_t;

    // Outputs toward the RF front end
    // MSB first in the packed layout
    typedef struct packed {
        // Attenuation code as applied
        dsa_code_t code;
        // Latch enable strobe, one cycle per processor update
        logic      le;
        // LNA bypass request from software
        logic      lna_bypass;
    } dsa_drive_t;

endpackage

/* flist.f */
+incdir+.
dsa_pkg.sv
alarm_pkg.sv
alarm_sync.sv
ps_dsa_request.sv
dsa_arbiter.sv
agc_adcp_top.sv
agc_adcp_sva.sv
agc_adcp_checker.sv
agc_adcp_tb.sv

/* ps_dsa_request.sv */
module ps_dsa_request
    import dsa_pkg::*;
(
    input  logic      axi_clk,
    input  logic      reset,
    input  logic      clk_en,
    input  dsa_code_t ps_rxdsa,
    output dsa_code_t ps_code,
    output logic      ps_change
);

    // Two stages bring the register value into the clock domain
    dsa_code_t ps_d1_q;
    dsa_code_t ps_d2_q;

    // First stage is the requested code
    assign ps_code = ps_d1_q;

    // Both stages start at full attenuation
    // so no change is seen out of reset
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            ps_d1_q <= '1;
            ps_d2_q <= '1;
        end else if (clk_en) begin
            ps_d1_q <= ps_rxdsa;
            ps_d2_q <= ps_d1_q;
        end
    end

    // Change flag, one enabled cycle per new value
    // Writing the same code again leaves both stages equal
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            ps_change <= 1'b0;
        end else if (clk_en) begin
            ps_change <= (ps_d1_q != ps_d2_q);
        end
    end

endmodule
